//--- logic/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // ************************************************************
    // Frame and timing constants
    // ************************************************************

    // Data bits per frame
    localparam int byte_bits = 8;

    // Quiet cycles before the host may take the bus
    localparam logic [7:0] idle_quiet_cycles = 8'd255;

    // Host timing in microseconds, scaled by the clock rate in the timer
    localparam int inhibit_us          = 101;
    localparam int start_timeout_us    = 15000;
    localparam int transfer_timeout_us = 2000;

    // Phase timer width
    localparam int timer_width = 32;

    // ************************************************************
    // Shared types
    // ************************************************************

    // Synchronised line view, strobes last one cycle
    typedef struct packed {
        logic clk_rise;
        logic clk_fall;
        logic data;
    } ps2_line_t;

    typedef enum logic [1:0] {
        phase_none,
        phase_inhibit,
        phase_wait_clock,
        phase_transfer
    } timer_phase_t;

    typedef struct packed {
        logic inhibit_half;
        logic inhibit_done;
        logic start_expired;
        logic transfer_expired;
    } timer_status_t;

    typedef enum logic [1:0] {
        link_idle,
        link_receive,
        link_command
    } link_state_t;

    typedef enum logic [2:0] {
        cmd_idle,
        cmd_inhibit,
        cmd_wait_clock,
        cmd_data,
        cmd_stop,
        cmd_ack,
        cmd_sent,
        cmd_error
    } cmd_state_t;

    // Active-high open-drain pull-downs
    typedef struct packed {
        logic pull_clk;
        logic pull_data;
    } cmd_drive_t;

endpackage

`default_nettype wire

//--- logic/ps2_line_sync.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync
(
    input  wire                clk,
    input  wire                reset,
    input  wire                ps2_clk_in,
    input  wire                ps2_dat_in,
    output ps2_pkg::ps2_line_t line
);

    // Two flop stages per pin, stage 1 is the settled one
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    // Previous settled clock sample for edge detection
    logic       clk_prev;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Idle bus level is high
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk_in};
            dat_sync <= {dat_sync[0], ps2_dat_in};
            clk_prev <= clk_sync[1];
        end
    end

    // One-cycle strobes from the last two clock samples
    assign line.clk_rise = clk_sync[1] & ~clk_prev;
    assign line.clk_fall = ~clk_sync[1] & clk_prev;
    // Data aligned with the clock samples
    assign line.data     = dat_sync[1];

endmodule

`default_nettype wire

//--- logic/ps2_link_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_link_fsm
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire ps2_pkg::ps2_line_t line,
    input  wire                     send_command,
    input  wire                     rx_done,
    output logic                    rx_start,
    output logic                    cmd_request
);

    ps2_pkg::link_state_t state;
    ps2_pkg::link_state_t state_next;

    // Cycles since the last clock activity in idle
    logic [$bits(ps2_pkg::idle_quiet_cycles)-1:0] quiet_count;
    logic start_bit;
    logic quiet;

    // Start bit is data low at a clock rise
    assign start_bit = line.clk_rise & ~line.data;
    assign quiet     = (quiet_count == ps2_pkg::idle_quiet_cycles);

    // ************************************************************
    // Bus arbitration
    // ************************************************************

    always_comb
    begin
        state_next = state;
        case (state)
            ps2_pkg::link_idle:
            begin
                // Device frame wins over a pending command
                if (start_bit)
                    state_next = ps2_pkg::link_receive;
                else if (quiet && send_command)
                    state_next = ps2_pkg::link_command;
            end
            ps2_pkg::link_receive:
            begin
                if (rx_done)
                    state_next = ps2_pkg::link_idle;
            end
            ps2_pkg::link_command:
            begin
                // Hold the grant for the whole request
                if (!send_command)
                    state_next = ps2_pkg::link_idle;
            end
            default:
                state_next = ps2_pkg::link_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ps2_pkg::link_idle;
        else
            state <= state_next;
    end

    // Quiet counter, restarted by any clock edge or by leaving idle
    always_ff @(posedge clk)
    begin
        if (reset)
            quiet_count <= '0;
        else if (state != ps2_pkg::link_idle || line.clk_rise || line.clk_fall)
            quiet_count <= '0;
        else if (!quiet)
            quiet_count <= quiet_count + 1'b1;
    end

    assign rx_start    = (state == ps2_pkg::link_idle) && start_bit;
    assign cmd_request = (state == ps2_pkg::link_command);

endmodule

`default_nettype wire

//--- logic/ps2_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_receiver
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire ps2_pkg::ps2_line_t        line,
    input  wire                            rx_start,
    output logic [ps2_pkg::byte_bits-1:0]  received_data,
    output logic                           rx_done
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    rx_state_t state;
    rx_state_t state_next;

    // Data bits taken so far
    logic [$clog2(ps2_pkg::byte_bits)-1:0] bit_count;
    logic [ps2_pkg::byte_bits-1:0]         shift_reg;
    logic                                  last_bit;

    assign last_bit = (int'(bit_count) == ps2_pkg::byte_bits - 1);

    always_comb
    begin
        state_next = state;
        case (state)
            rx_idle:
            begin
                // Start bit already seen by the link FSM
                if (rx_start)
                    state_next = rx_data;
            end
            rx_data:
            begin
                if (line.clk_rise && last_bit)
                    state_next = rx_parity;
            end
            rx_parity:
            begin
                // Parity bit skipped, not checked
                if (line.clk_rise)
                    state_next = rx_stop;
            end
            default:
            begin
                if (line.clk_rise)
                    state_next = rx_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= rx_idle;
            bit_count <= '0;
            rx_done   <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (state == rx_data && line.clk_rise)
                bit_count <= bit_count + 1'b1;
            else if (state != rx_data)
                bit_count <= '0;
            // Valid pulse in the cycle after the stop edge
            rx_done <= (state == rx_stop) && line.clk_rise;
        end
    end

    // Payload path, LSB first
    always_ff @(posedge clk)
    begin
        if (state == rx_data && line.clk_rise)
            shift_reg <= {line.data, shift_reg[ps2_pkg::byte_bits-1:1]};
        if (state == rx_stop && line.clk_rise)
            received_data <= shift_reg;
    end

endmodule

`default_nettype wire

//--- logic/ps2_command_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_command_fsm
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire ps2_pkg::ps2_line_t      line,
    input  wire [ps2_pkg::byte_bits-1:0] command,
    input  wire                          cmd_request,
    input  wire ps2_pkg::timer_status_t  status,
    output ps2_pkg::timer_phase_t        phase,
    output ps2_pkg::cmd_drive_t          drive,
    output logic                         command_sent,
    output logic                         command_timed_out
);

    ps2_pkg::cmd_state_t state;
    ps2_pkg::cmd_state_t state_next;

    // Odd parity bit above the command byte
    logic [ps2_pkg::byte_bits:0]               frame;
    logic [$clog2(ps2_pkg::byte_bits+1)-1:0]   bit_index;
    logic                                      last_bit;

    // Parity is the last bit driven in the data state
    assign last_bit = (int'(bit_index) == ps2_pkg::byte_bits);

    // ************************************************************
    // Transmit sequence
    // ************************************************************

    always_comb
    begin
        state_next = state;
        if (!cmd_request)
            state_next = ps2_pkg::cmd_idle;
        else
        begin
            case (state)
                ps2_pkg::cmd_idle:
                    state_next = ps2_pkg::cmd_inhibit;
                ps2_pkg::cmd_inhibit:
                    if (status.inhibit_done)
                        state_next = ps2_pkg::cmd_wait_clock;
                ps2_pkg::cmd_wait_clock:
                    // First device clock low starts the transfer
                    if (line.clk_fall)
                        state_next = ps2_pkg::cmd_data;
                    else if (status.start_expired)
                        state_next = ps2_pkg::cmd_error;
                ps2_pkg::cmd_data:
                    if (line.clk_fall && last_bit)
                        state_next = ps2_pkg::cmd_stop;
                    else if (status.transfer_expired)
                        state_next = ps2_pkg::cmd_error;
                ps2_pkg::cmd_stop:
                    if (line.clk_fall)
                        state_next = ps2_pkg::cmd_ack;
                    else if (status.transfer_expired)
                        state_next = ps2_pkg::cmd_error;
                ps2_pkg::cmd_ack:
                    // Acknowledge is data held low by the device at the rise
                    if (line.clk_rise && !line.data)
                        state_next = ps2_pkg::cmd_sent;
                    else if (status.transfer_expired)
                        state_next = ps2_pkg::cmd_error;
                default:
                    // Sent and error hold until the request drops
                    state_next = state;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= ps2_pkg::cmd_idle;
            bit_index <= '0;
        end
        else
        begin
            state <= state_next;
            // Next bit goes out while the device holds the clock low
            if (state == ps2_pkg::cmd_data && line.clk_fall)
                bit_index <= bit_index + 1'b1;
            else if (state != ps2_pkg::cmd_data)
                bit_index <= '0;
        end
    end

    // Byte tracks the input until the send starts
    always_ff @(posedge clk)
    begin
        if (state == ps2_pkg::cmd_idle)
            frame <= {~^command, command};
    end

    // Pull-downs and timer phase per state
    always_comb
    begin
        drive = '0;
        phase = ps2_pkg::phase_none;
        case (state)
            ps2_pkg::cmd_inhibit:
            begin
                drive.pull_clk  = 1'b1;
                // Request-to-send in the second half of the inhibit
                drive.pull_data = status.inhibit_half;
                phase           = ps2_pkg::phase_inhibit;
            end
            ps2_pkg::cmd_wait_clock:
            begin
                drive.pull_data = 1'b1;
                phase           = ps2_pkg::phase_wait_clock;
            end
            ps2_pkg::cmd_data:
            begin
                drive.pull_data = ~frame[bit_index];
                phase           = ps2_pkg::phase_transfer;
            end
            ps2_pkg::cmd_stop, ps2_pkg::cmd_ack:
                // Lines released, stop bit is the pull-up
                phase = ps2_pkg::phase_transfer;
            default:
                phase = ps2_pkg::phase_none;
        endcase
    end

    // Result levels drop with the request
    assign command_sent      = (state == ps2_pkg::cmd_sent) && cmd_request;
    assign command_timed_out = (state == ps2_pkg::cmd_error) && cmd_request;

endmodule

`default_nettype wire

//--- logic/ps2_host_timer.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host_timer
#(
    parameter int clk_khz = 50000
)
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire ps2_pkg::timer_phase_t  phase,
    output ps2_pkg::timer_status_t      status
);

    logic [ps2_pkg::timer_width-1:0] count;
    // Cycles spent in the phase before the current one
    logic [ps2_pkg::timer_width-1:0] elapsed;
    logic [ps2_pkg::timer_width-1:0] inhibit_limit;
    logic [ps2_pkg::timer_width-1:0] start_limit;
    logic [ps2_pkg::timer_width-1:0] transfer_limit;
    ps2_pkg::timer_phase_t           phase_last;
    logic                            fresh;

    // Period lengths in clk cycles
    assign inhibit_limit  = ps2_pkg::inhibit_us * clk_khz / 1000;
    assign start_limit    = ps2_pkg::start_timeout_us * clk_khz / 1000;
    assign transfer_limit = ps2_pkg::transfer_timeout_us * clk_khz / 1000;

    // First cycle of a new phase reads as zero
    assign fresh   = (phase == phase_last);
    assign elapsed = fresh ? count + 1'b1 : '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count      <= '0;
            phase_last <= ps2_pkg::phase_none;
        end
        else
        begin
            phase_last <= phase;
            if (phase == ps2_pkg::phase_none || !fresh)
                count <= '0;
            else if (elapsed != '1)
                count <= elapsed;
        end
    end

    // Flags rise in the last cycle of each period
    assign status.inhibit_half     = (phase == ps2_pkg::phase_inhibit) &&
                                     (elapsed >= inhibit_limit / 2);
    assign status.inhibit_done     = (phase == ps2_pkg::phase_inhibit) &&
                                     (elapsed >= inhibit_limit - 1);
    assign status.start_expired    = (phase == ps2_pkg::phase_wait_clock) &&
                                     (elapsed >= start_limit - 1);
    assign status.transfer_expired = (phase == ps2_pkg::phase_transfer) &&
                                     (elapsed >= transfer_limit - 1);

endmodule

`default_nettype wire

//--- logic/ps2_host.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host
#(
    parameter int clk_khz = 50000
)
(
    input  wire                            clk,
    input  wire                            reset,
    input  wire  [ps2_pkg::byte_bits-1:0]  command,
    input  wire                            send_command,
    inout  wire                            ps2_clk,
    inout  wire                            ps2_dat,
    output logic                           command_sent,
    output logic                           command_timed_out,
    output logic [ps2_pkg::byte_bits-1:0]  received_data,
    output logic                           received_valid
);

    ps2_pkg::ps2_line_t     line;
    ps2_pkg::timer_phase_t  phase;
    ps2_pkg::timer_status_t status;
    ps2_pkg::cmd_drive_t    drive;
    logic                   rx_start;
    logic                   cmd_request;

    // ************************************************************
    // Line sampling and arbitration
    // ************************************************************

    ps2_line_sync line_sync_i
    (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk_in (ps2_clk),
        .ps2_dat_in (ps2_dat),
        .line       (line)
    );

    ps2_link_fsm link_fsm_i
    (
        .clk          (clk),
        .reset        (reset),
        .line         (line),
        .send_command (send_command),
        .rx_done      (received_valid),
        .rx_start     (rx_start),
        .cmd_request  (cmd_request)
    );

    // Receive path, done pulse is the valid strobe
    ps2_receiver receiver_i
    (
        .clk           (clk),
        .reset         (reset),
        .line          (line),
        .rx_start      (rx_start),
        .received_data (received_data),
        .rx_done       (received_valid)
    );

    // Transmit path with its phase timer
    ps2_command_fsm command_fsm_i
    (
        .clk               (clk),
        .reset             (reset),
        .line              (line),
        .command           (command),
        .cmd_request       (cmd_request),
        .status            (status),
        .phase             (phase),
        .drive             (drive),
        .command_sent      (command_sent),
        .command_timed_out (command_timed_out)
    );

    ps2_host_timer #(.clk_khz(clk_khz)) host_timer_i
    (
        .clk    (clk),
        .reset  (reset),
        .phase  (phase),
        .status (status)
    );

    // Open-drain, pull-ups sit outside the chip
    assign ps2_clk = drive.pull_clk  ? 1'b0 : 1'bz;
    assign ps2_dat = drive.pull_data ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

//--- verification/ps2_host_properties.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_host_properties
(
    input wire                          clk,
    input wire                          reset,
    input wire                          send_command,
    input wire                          command_sent,
    input wire                          command_timed_out,
    input wire [ps2_pkg::byte_bits-1:0] received_data,
    input wire                          received_valid
);

    // Failed checks so far, polled by the testbench
    int violation_count = 0;

    // ************************************************************
    // Port checks
    // ************************************************************

    // Outputs quiet right after reset
    reset_outputs_a: assert property (@(posedge clk)
        reset |=> !command_sent && !command_timed_out && !received_valid)
    else
    begin
        violation_count++;
        $error("[ERROR] %0t outputs not low after reset", $time);
    end

    // Valid strobe lasts one cycle
    valid_pulse_a: assert property (@(posedge clk) disable iff (reset)
        received_valid |=> !received_valid)
    else
    begin
        violation_count++;
        $error("[ERROR] %0t received_valid high for a second cycle", $time);
    end

    // Never both results at once
    result_exclusive_a: assert property (@(posedge clk) disable iff (reset)
        !(command_sent && command_timed_out))
    else
    begin
        violation_count++;
        $error("[ERROR] %0t command_sent and command_timed_out high together", $time);
    end

    // Result levels drop one cycle after the request
    result_clear_a: assert property (@(posedge clk) disable iff (reset)
        !send_command |=> !command_sent && !command_timed_out)
    else
    begin
        violation_count++;
        $error("[ERROR] %0t result level still high after send_command fell", $time);
    end

    // Byte only moves together with the strobe
    data_hold_a: assert property (@(posedge clk) disable iff (reset)
        !received_valid && !$isunknown($past(received_data)) |->
            received_data == $past(received_data))
    else
    begin
        violation_count++;
        $error("[ERROR] %0t received_data changed without received_valid", $time);
    end

endmodule

bind ps2_host ps2_host_properties properties_i (.*);

`default_nettype wire

//--- verification/tb_ps2_host.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ps2_host;

    // Device clock timing in system cycles
    localparam int bit_cycles  = 40;
    localparam int lead_cycles = 10;
    localparam int low_cycles  = 20;
    // Test lengths for the watchdog
    localparam int frame_cycles    = 12 * bit_cycles;
    localparam int rts_cycles      = 255 + 101 + 100;
    localparam int command_cycles  = rts_cycles + 13 * bit_cycles + 100;
    localparam int timeout_cycles  = 255 + 101 + 15000 + 200;
    localparam int watchdog_cycles = 9 * frame_cycles + 2 * command_cycles
                                     + timeout_cycles + 2000;
    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic       clk = 1'b0;
    logic       reset;
    logic [7:0] command;
    logic       send_command;
    logic       command_sent;
    logic       command_timed_out;
    logic [7:0] received_data;
    logic       received_valid;

    // Bus lines with external pull-ups
    tri1 ps2_clk;
    tri1 ps2_dat;

    // Device side open-drain pull-downs
    logic dev_clk_low;
    logic dev_dat_low;
    // Set while a device frame waits for its valid strobe
    logic frame_pending;
    logic host_pulls_clk;
    logic host_pulls_dat;

    logic [31:0] lfsr_state;
    logic [7:0]  rx_byte;
    logic [7:0]  cmd_byte;

    always #10 clk = ~clk;

    assign ps2_clk = dev_clk_low ? 1'b0 : 1'bz;
    assign ps2_dat = dev_dat_low ? 1'b0 : 1'bz;

    // Low line not caused by the device
    assign host_pulls_clk = (ps2_clk === 1'b0) && !dev_clk_low;
    assign host_pulls_dat = (ps2_dat === 1'b0) && !dev_dat_low;

    ps2_host #(.clk_khz(1000)) ps2_host_i
    (
        .clk               (clk),
        .reset             (reset),
        .command           (command),
        .send_command      (send_command),
        .ps2_clk           (ps2_clk),
        .ps2_dat           (ps2_dat),
        .command_sent      (command_sent),
        .command_timed_out (command_timed_out),
        .received_data     (received_data),
        .received_valid    (received_valid)
    );

    // ************************************************************
    // Failure reporting and random bytes
    // ************************************************************

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_failure(input string reason);
        $display("Failure at %0t ns, %s", $time, reason);
        stop_with_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ lfsr_taps;
        return shifted;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    // ************************************************************
    // Device model
    // ************************************************************

    // Data set mid-high, sampled by the host at the release
    task automatic clock_out_bit(input logic value);
        wait_cycles(lead_cycles);
        dev_dat_low <= ~value;
        wait_cycles(lead_cycles);
        dev_clk_low <= 1'b1;
        wait_cycles(low_cycles);
        dev_clk_low <= 1'b0;
    endtask

    // Start, data LSB first, odd parity, stop
    task automatic send_frame(input logic [7:0] value, input int send_at_bit);
        logic [10:0] bits;
        bits = {1'b1, ~^value, value, 1'b0};
        frame_pending <= 1'b1;
        for (int i = 0; i < 11; i++)
        begin
            // Command request raised in the middle of the frame
            if (i == send_at_bit)
                send_command <= 1'b1;
            clock_out_bit(bits[i]);
        end
    endtask

    task automatic expect_received(input logic [7:0] value);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!received_valid && waited < 20)
        begin
            waited++;
            @(negedge clk);
        end
        assert (received_valid)
        else report_failure("received_valid did not appear after the stop bit");
        assert (received_data == value)
        else report_mismatch("received_data", value, received_data);
        frame_pending <= 1'b0;
    endtask

    // Wait for request-to-send, clock in 10 bits, then acknowledge
    task automatic answer_command(input logic [7:0] value);
        logic [9:0] bits;
        int         waited;
        waited = 0;
        @(negedge clk);
        while (!(ps2_clk === 1'b1 && ps2_dat === 1'b0) && waited < rts_cycles)
        begin
            waited++;
            @(negedge clk);
        end
        assert (ps2_clk === 1'b1 && ps2_dat === 1'b0)
        else report_failure("host never signalled request-to-send");
        for (int i = 0; i < 10; i++)
        begin
            wait_cycles(lead_cycles);
            dev_clk_low <= 1'b1;
            wait_cycles(low_cycles);
            bits[i] = ps2_dat;
            dev_clk_low <= 1'b0;
            wait_cycles(bit_cycles - lead_cycles - low_cycles);
        end
        // Acknowledge is data low over one more clock
        dev_dat_low <= 1'b1;
        wait_cycles(lead_cycles);
        dev_clk_low <= 1'b1;
        wait_cycles(low_cycles);
        dev_clk_low <= 1'b0;
        wait_cycles(lead_cycles);
        dev_dat_low <= 1'b0;
        assert (bits[7:0] == value)
        else report_mismatch("command data bits", value, bits[7:0]);
        assert ((^bits[8:0]) == 1'b1)
        else report_failure("parity bit does not make the nine bits odd");
        assert (bits[9] == 1'b1)
        else report_mismatch("stop bit", 8'd1, {7'd0, bits[9]});
    endtask

    // ************************************************************
    // Host result checks
    // ************************************************************

    task automatic expect_command_sent();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!command_sent && waited < 100)
        begin
            waited++;
            @(negedge clk);
        end
        assert (command_sent)
        else report_failure("command_sent did not rise after the acknowledge");
        assert (!command_timed_out)
        else report_mismatch("command_timed_out", 8'd0, {7'd0, command_timed_out});
        // Level holds while the request stays up
        repeat (20)
        begin
            @(negedge clk);
            assert (command_sent)
            else report_mismatch("command_sent", 8'd1, {7'd0, command_sent});
        end
    endtask

    task automatic expect_timeout();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!command_timed_out && waited < timeout_cycles)
        begin
            waited++;
            @(negedge clk);
        end
        assert (command_timed_out)
        else report_failure("command_timed_out did not rise without a device clock");
        assert (!command_sent)
        else report_mismatch("command_sent", 8'd0, {7'd0, command_sent});
        assert (ps2_clk === 1'b1)
        else report_mismatch("ps2_clk", 8'd1, {7'd0, ps2_clk});
        assert (ps2_dat === 1'b1)
        else report_mismatch("ps2_dat", 8'd1, {7'd0, ps2_dat});
    endtask

    // Results clear one cycle after the request falls
    task automatic drop_send_command();
        @(posedge clk);
        send_command <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        assert (!command_sent && !command_timed_out)
        else report_failure("result level still high after send_command fell");
    endtask

    // Host leaves both lines alone without a request
    lines_released_a: assert property (@(posedge clk) disable iff (reset)
        !send_command && !$past(send_command) && !$past(send_command, 2) |->
            !host_pulls_clk && !host_pulls_dat)
    else report_failure("host pulled a PS/2 line low without a command");

    // No inhibit before the pending frame is delivered
    frame_first_a: assert property (@(posedge clk) disable iff (reset)
        frame_pending |-> !host_pulls_clk)
    else report_failure("host pulled ps2_clk low during a device frame");

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial
    begin
        reset         = 1'b1;
        command       = '0;
        send_command  = 1'b0;
        dev_clk_low   = 1'b0;
        dev_dat_low   = 1'b0;
        frame_pending = 1'b0;
        lfsr_state    = 32'd32;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait_cycles(5);

        // Receive eight random frames
        repeat (8)
        begin
            draw_byte(rx_byte);
            send_frame(rx_byte, -1);
            expect_received(rx_byte);
            wait_cycles(bit_cycles);
        end

        // Command answered by the device
        draw_byte(cmd_byte);
        command      <= cmd_byte;
        send_command <= 1'b1;
        answer_command(cmd_byte);
        expect_command_sent();
        drop_send_command();

        // Device never clocks
        wait_cycles(bit_cycles);
        draw_byte(cmd_byte);
        command      <= cmd_byte;
        send_command <= 1'b1;
        expect_timeout();
        drop_send_command();

        // Request arrives mid-frame
        wait_cycles(bit_cycles);
        draw_byte(rx_byte);
        draw_byte(cmd_byte);
        command <= cmd_byte;
        send_frame(rx_byte, 5);
        expect_received(rx_byte);
        answer_command(cmd_byte);
        expect_command_sent();
        drop_send_command();

        wait_cycles(10);
        if (ps2_host_i.properties_i.violation_count == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
            report_failure("a bound property on the DUT ports failed");
    end

    // Bound properties stop the run at once
    initial
    begin
        wait (ps2_host_i.properties_i.violation_count != 0);
        report_failure("a bound property on the DUT ports failed");
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        report_failure("the run timed out before all tests finished");
    end

endmodule

`default_nettype wire

//--- flist.f
logic/ps2_pkg.sv
logic/ps2_line_sync.sv
logic/ps2_link_fsm.sv
logic/ps2_receiver.sv
logic/ps2_command_fsm.sv
logic/ps2_host_timer.sv
logic/ps2_host.sv
verification/ps2_host_properties.sv
verification/tb_ps2_host.sv
